/* compile.f */
+incdir+tests
src/seq_pkg.sv
src/seq_issue.sv
src/seq_loop_counters.sv
src/seq_addr_gen.sv
src/seq_top.sv
tests/seq_tb.sv

/* Makefile */
# Verilator flow for the microcode sequencer

TOP = seq_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module seq_top -f compile.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

obj_dir/V$(TOP): compile.f src/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/seq_tb_prog.svh */
//--------------------
// Test programs and reference model for the sequencer testbench
// Included inside the testbench module. Builds prog[] and the
// expected ctrl and address lists, plus the busy LFSR.
//--------------------
`ifndef SEQ_TB_PROG_SVH
`define SEQ_TB_PROG_SVH
`default_nettype none

// Galois LFSR with taps x^32+x^22+x^2+x+1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
endfunction

// Word with mac_en set and its index as tag in {nl_sel, olsb}
function automatic seq_pkg::inst_t tagged_word(input int tag);
    seq_pkg::inst_t w;
    w = '0;
    w.ctrl.mac_en = 1'b1;
    {w.ctrl.nl_sel, w.ctrl.olsb} = tag[5:0];
    return w;
endfunction

function automatic seq_pkg::addr_field_t addr_load(input logic [15:0] v);
    return {1'b1, 1'b0, v};
endfunction

function automatic seq_pkg::addr_field_t addr_up(input logic [14:0] n, input logic bak);
    return {1'b0, bak, 1'b0, n};
endfunction

function automatic seq_pkg::addr_field_t addr_down(input logic [14:0] n, input logic bak);
    return {1'b0, bak, 1'b1, n};
endfunction

task automatic load_prog(input int p);
    logic fin_seen;
    for (int i = 0; i < 64; i++)
        prog[i] = tagged_word(i);
    case (p)
        // Straight-line loads, adds and subtracts
        0:
        begin
            prog[0].addr_rx = addr_load(16'd100);
            prog[0].addr_rw = addr_load(16'h2000);
            prog[0].addr_wx = addr_load(16'h0500);
            prog[1].addr_rx = addr_up(15'd3, 1'b0);
            prog[1].addr_rw = addr_down(15'h10, 1'b0);
            prog[1].addr_wx = addr_up(15'd1, 1'b0);
            prog[2].addr_rx = addr_down(15'd7, 1'b0);
            prog[2].addr_rw = addr_up(15'h100, 1'b0);
            prog[2].addr_wx = addr_down(15'd2, 1'b0);
            prog[3].addr_rx = addr_up(15'h7fff, 1'b0);
            prog[3].addr_rw = addr_down(15'd1, 1'b0);
            prog[3].addr_wx = addr_load(16'hffff);
            prog[4].addr_rx = addr_down(15'd200, 1'b0);
            prog[4].addr_wx = addr_up(15'd1, 1'b0);
            prog[4].ctrl.seq_fin = 1'b1;
        end
        // Outer loop of 3 around an inner loop of 4 on word 2
        1:
        begin
            prog[0].cnt_we = 1'b1;
            prog[0].cnt_sel = 2'd0;
            prog[0].cnt_value = 16'd3;
            prog[1].cnt_we = 1'b1;
            prog[1].cnt_sel = 2'd1;
            prog[1].cnt_value = 16'd4;
            prog[2].addr_rx = addr_up(15'd1, 1'b0);
            prog[2].jump_sel = 4'b0010;
            prog[2].jump_target = 10'd2;
            prog[3].addr_rw = addr_up(15'd1, 1'b0);
            prog[3].jump_sel = 4'b0001;
            prog[3].jump_target = 10'd1;
            prog[4].ctrl.seq_fin = 1'b1;
        end
        // Backup and restore under wait words
        default:
        begin
            prog[0].addr_rx = addr_load(16'h40);
            prog[0].addr_rw = addr_load(16'h80);
            prog[0].addr_wx = addr_load(16'h10);
            prog[1].addr_rx = addr_up(15'd4, 1'b1);
            prog[1].addr_rw = addr_up(15'd8, 1'b1);
            prog[1].addr_wx = addr_up(15'd1, 1'b1);
            prog[2].addr_rx = addr_up(15'd4, 1'b0);
            prog[2].addr_rw = addr_down(15'd8, 1'b0);
            prog[3].addr_rx = addr_up(15'd4, 1'b1);
            prog[3].addr_rw = addr_up(15'd4, 1'b1);
            prog[3].addr_wx = addr_up(15'd2, 1'b1);
            prog[4].addr_rx = addr_up(15'd1, 1'b0);
            prog[4].addr_wx = addr_down(15'd1, 1'b0);
            prog[5].addr_rx = addr_load(16'd5);
            prog[5].addr_rx.bak = 1'b1;
            prog[6].addr_rx = addr_up(15'd9, 1'b1);
            prog[7].ctrl.seq_fin = 1'b1;
            for (int i = 0; i < 8; i++)
                prog[i].wait_sel = 3'(i + 1);
        end
    endcase
    // The sequencer runs on past the final word, so what follows is empty
    fin_seen = 1'b0;
    for (int i = 0; i < 64; i++)
    begin
        if (fin_seen)
            prog[i] = '0;
        fin_seen = fin_seen | prog[i].ctrl.seq_fin;
    end
endtask

// Walks prog[] by the execution rules and fills the expected lists
task automatic run_model();
    logic [15:0]          cnt [0:3];
    logic [15:0]          ax [0:2];
    logic [15:0]          bk [0:2];
    seq_pkg::addr_field_t f [0:2];
    seq_pkg::inst_t       w;
    logic [15:0]          old;
    logic                 take;
    logic                 done;
    int                   pc;
    for (int i = 0; i < 4; i++)
        cnt[i] = '0;
    for (int g = 0; g < 3; g++)
    begin
        ax[g] = '0;
        bk[g] = '0;
    end
    pc = 0;
    n_exp = 0;
    done = 1'b0;
    while (!done && n_exp < 64)
    begin
        w = prog[pc];
        exp_ctrl[n_exp] = w.ctrl;
        take = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            if (w.jump_sel[i] && cnt[i] != 16'd1)
                take = 1'b1;
            if (w.cnt_we && w.cnt_sel == 2'(i))
                cnt[i] = (cnt[i] == 0) ? w.cnt_value : cnt[i];
            else if (w.jump_sel[i])
                cnt[i] = cnt[i] - 16'd1;
        end
        f[0] = w.addr_rx;
        f[1] = w.addr_rw;
        f[2] = w.addr_wx;
        for (int g = 0; g < 3; g++)
        begin
            old = ax[g];
            if (f[g].we)
                ax[g] = f[g].value;
            else if (g < 2 && f[g].bak && bk[g] != 0)
                ax[g] = bk[g];
            else if (f[g].value[15])
                ax[g] = old - {1'b0, f[g].value[14:0]};
            else
                ax[g] = old + {1'b0, f[g].value[14:0]};
            if (g < 2 && f[g].bak)
                bk[g] = (bk[g] == 0) ? old : 16'd0;
        end
        exp_rx[n_exp] = ax[0];
        exp_rw[n_exp] = ax[1];
        exp_wx[n_exp] = ax[2];
        n_exp++;
        done = w.ctrl.seq_fin;
        pc = take ? int'(w.jump_target) : pc + 1;
    end
endtask

`default_nettype wire
`endif

/* tests/seq_tb.sv */
//--------------------
// Testbench for the microcode sequencer
// Runs three programs from a memory model, checks fired control words
// and address outputs against a reference model by assertions.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module seq_tb;

    logic                          CLK;
    logic                          RSTL;
    logic                          purge;
    logic                          mbusy_w;
    logic                          mbusy_xi;
    logic                          mbusy_xo;
    seq_pkg::inst_t                instr;
    logic [seq_pkg::PC_W-1:0]      inst_addr;
    logic [seq_pkg::ADDR_W-1:0]    raddr_x;
    logic [seq_pkg::ADDR_W-1:0]    raddr_w;
    logic [seq_pkg::ADDR_W-1:0]    waddr_x;
    logic                          bank_x;
    logic                          bank_w;
    logic                          rceb_x;
    logic                          wceb_x;
    logic                          req_w;
    logic                          mac_en;
    logic                          nl_en;
    logic [1:0]                    nl_sel;
    logic                          seq_fin;
    logic [3:0]                    olsb;
    seq_pkg::ctrl_t                got_ctrl;

    // Memory model, program image and expected results
    seq_pkg::inst_t                mem [0:1023];
    seq_pkg::inst_t                prog [0:63];
    seq_pkg::ctrl_t                exp_ctrl [0:63];
    logic [seq_pkg::ADDR_W-1:0]    exp_rx [0:63];
    logic [seq_pkg::ADDR_W-1:0]    exp_rw [0:63];
    logic [seq_pkg::ADDR_W-1:0]    exp_wx [0:63];
    int                            n_exp;

    logic                          chk_en;
    logic                          busy_en;
    int                            fire_idx;
    int                            chk_idx;
    logic                          chk_pending;
    logic                          last_wait;
    logic                          purge_q;
    int                            body_cnt;
    int                            cycle_cnt;
    int                            limit;
    logic [seq_pkg::PC_W-1:0]      fetch_addr;
    logic [31:0]                   lfsr;

    seq_top u_seq_top (
        .CLK (CLK), .RSTL (RSTL), .purge (purge),
        .mbusy_w (mbusy_w), .mbusy_xi (mbusy_xi), .mbusy_xo (mbusy_xo),
        .instr (instr), .inst_addr (inst_addr),
        .raddr_x (raddr_x), .raddr_w (raddr_w), .waddr_x (waddr_x),
        .bank_x (bank_x), .bank_w (bank_w), .rceb_x (rceb_x), .wceb_x (wceb_x),
        .req_w (req_w), .mac_en (mac_en), .nl_en (nl_en), .nl_sel (nl_sel),
        .seq_fin (seq_fin), .olsb (olsb)
    );

    assign got_ctrl = {bank_x, bank_w, rceb_x, wceb_x, req_w, mac_en, nl_en, nl_sel,
                       seq_fin, olsb};

    always #2 CLK = ~CLK;

    // Instruction memory with one-cycle read
    always @(posedge CLK)
    begin
        fetch_addr = inst_addr;
        #1;
        instr = mem[fetch_addr];
    end

    // Each busy level is high when two LFSR bits are both set
    always @(posedge CLK)
    begin
        #1;
        if (busy_en)
        begin
            mbusy_w  = lfsr[0];
            lfsr     = lfsr_next(lfsr);
            mbusy_w  = mbusy_w & lfsr[0];
            lfsr     = lfsr_next(lfsr);
            mbusy_xi = lfsr[0];
            lfsr     = lfsr_next(lfsr);
            mbusy_xi = mbusy_xi & lfsr[0];
            lfsr     = lfsr_next(lfsr);
            mbusy_xo = lfsr[0];
            lfsr     = lfsr_next(lfsr);
            mbusy_xo = mbusy_xo & lfsr[0];
            lfsr     = lfsr_next(lfsr);
        end
        else
        begin
            {mbusy_xo, mbusy_xi, mbusy_w} = '0;
        end
    end

    // --------------------
    // Check bookkeeping
    // --------------------
    always @(posedge CLK)
    begin
        cycle_cnt   <= cycle_cnt + 1;
        purge_q     <= purge;
        last_wait   <= |(instr.wait_sel & {mbusy_xo, mbusy_xi, mbusy_w});
        chk_pending <= chk_en && mac_en;
        chk_idx     <= fire_idx;
        if (!chk_en)
        begin
            fire_idx <= 0;
            body_cnt <= 0;
        end
        else if (mac_en)
        begin
            fire_idx <= fire_idx + 1;
            if ({nl_sel, olsb} == 6'd2)
                body_cnt <= body_cnt + 1;
        end
        if (cycle_cnt >= limit)
            report_problem("Timeout, the DUT stopped firing the expected words");
    end

    // --------------------
    // Assertions
    // --------------------
    a_reset: assert property (@(posedge CLK) !RSTL |-> (inst_addr == '0 && got_ctrl == '0
        && raddr_x == '0 && raddr_w == '0 && waddr_x == '0))
        else report_problem("Outputs not zero during reset");

    // Every test word carries mac_en, so no other pin may pulse alone
    a_idle: assert property (@(posedge CLK) disable iff (!RSTL)
        !mac_en |-> (got_ctrl == '0))
        else report_mismatch("ctrl", 32'd0, $sampled(got_ctrl));

    a_count: assert property (@(posedge CLK) disable iff (!RSTL)
        (chk_en && mac_en) |-> (fire_idx < n_exp))
        else report_problem("More control pulses than fired words in the model");

    a_ctrl: assert property (@(posedge CLK) disable iff (!RSTL)
        (chk_en && mac_en) |-> (got_ctrl == exp_ctrl[fire_idx]))
        else report_mismatch("ctrl", exp_ctrl[$sampled(fire_idx)], $sampled(got_ctrl));

    a_rx: assert property (@(posedge CLK) disable iff (!RSTL)
        chk_pending |-> (raddr_x == exp_rx[chk_idx]))
        else report_mismatch("raddr_x", exp_rx[$sampled(chk_idx)], $sampled(raddr_x));

    a_rw: assert property (@(posedge CLK) disable iff (!RSTL)
        chk_pending |-> (raddr_w == exp_rw[chk_idx]))
        else report_mismatch("raddr_w", exp_rw[$sampled(chk_idx)], $sampled(raddr_w));

    a_wx: assert property (@(posedge CLK) disable iff (!RSTL)
        chk_pending |-> (waddr_x == exp_wx[chk_idx]))
        else report_mismatch("waddr_x", exp_wx[$sampled(chk_idx)], $sampled(waddr_x));

    a_wait: assert property (@(posedge CLK) disable iff (!RSTL) mac_en |-> !last_wait)
        else report_problem("A word fired while its selected busy input was high");

    a_purge: assert property (@(posedge CLK) disable iff (!RSTL)
        purge_q |-> (inst_addr == '0 && got_ctrl == '0))
        else report_problem("PC or control outputs not cleared one edge after purge");

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        $display("Error at %0t: %s expected %h got %h", $time, sig, exp_v, got_v);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string msg);
        $display("%s at %0t", msg, $time);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Purge for two edges while the memory image loads
    task automatic purge_and_load();
        @(posedge CLK);
        #1;
        purge   = 1'b1;
        chk_en  = 1'b0;
        busy_en = 1'b0;
        for (int a = 0; a < 1024; a++)
            mem[a] = (a < 64) ? prog[a] : '0;
        repeat (2) @(posedge CLK);
        #1;
        purge  = 1'b0;
        chk_en = 1'b1;
    endtask

    task automatic run_program(input int p, input int purge_after);
        load_prog(p);
        run_model();
        purge_and_load();
        busy_en = (p == 2);
        if (purge_after > 0)
        begin
            while (fire_idx < purge_after)
                @(posedge CLK);
            purge_and_load();
            busy_en = 1'b1;
        end
        while (fire_idx < n_exp)
            @(posedge CLK);
        repeat (8) @(posedge CLK);
    endtask

    initial
    begin
        int total;
        CLK = 1'b0;
        RSTL = 1'b0;
        purge = 1'b0;
        {mbusy_xo, mbusy_xi, mbusy_w} = '0;
        instr = '0;
        chk_en = 1'b0;
        busy_en = 1'b0;
        lfsr = 32'h330cdc7a;
        cycle_cnt = 0;
        total = 0;
        for (int p = 0; p < 3; p++)
        begin
            load_prog(p);
            run_model();
            total += (p == 2) ? 2 * n_exp : n_exp;
        end
        limit = total * 20 + 200;
        for (int a = 0; a < 1024; a++)
            mem[a] = '0;
        repeat (5) @(posedge CLK);
        #1;
        RSTL = 1'b1;
        run_program(0, 0);
        run_program(1, 0);
        if (body_cnt != 12)
            report_problem("Nested loop body did not run 12 times");
        run_program(2, 4);
        if (fire_idx == n_exp)
        begin
            $display("Verification passed");
            $finish;
        end
        else
        begin
            report_problem("Fired word count differs from the model");
        end
    end

`include "seq_tb_prog.svh"

endmodule

`default_nettype wire

/* src/seq_top.sv */
//--------------------
// Microcode sequencer top level
// Fetches from an external instruction memory with one-cycle read,
// drives the data-memory addresses and the accelerator control pins.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module seq_top (
    input  wire                            CLK,
    input  wire                            RSTL,
    input  wire                            purge,
    input  wire                            mbusy_w,
    input  wire                            mbusy_xi,
    input  wire                            mbusy_xo,
    input  wire [seq_pkg::INST_W-1:0]      instr,
    output wire [seq_pkg::PC_W-1:0]        inst_addr,
    output wire [seq_pkg::ADDR_W-1:0]      raddr_x,
    output wire [seq_pkg::ADDR_W-1:0]      raddr_w,
    output wire [seq_pkg::ADDR_W-1:0]      waddr_x,
    output wire                            bank_x,
    output wire                            bank_w,
    output wire                            rceb_x,
    output wire                            wceb_x,
    output wire                            req_w,
    output wire                            mac_en,
    output wire                            nl_en,
    output wire [1:0]                      nl_sel,
    output wire                            seq_fin,
    output wire [3:0]                      olsb
);

    logic [seq_pkg::NUM_BUSY-1:0]  busy;
    logic [seq_pkg::NUM_LOOPS-1:0] cnt_last;
    logic                          fire;
    seq_pkg::inst_t                inst;
    seq_pkg::ctrl_t                ctrl;

    assign busy[seq_pkg::BUSY_W]  = mbusy_w;
    assign busy[seq_pkg::BUSY_XI] = mbusy_xi;
    assign busy[seq_pkg::BUSY_XO] = mbusy_xo;

    // --------------------
    // Issue and loops
    // --------------------
    seq_issue u_issue (
        .CLK       (CLK),
        .RSTL      (RSTL),
        .purge     (purge),
        .busy      (busy),
        .instr     (instr),
        .cnt_last  (cnt_last),
        .inst      (inst),
        .fire      (fire),
        .inst_addr (inst_addr),
        .ctrl      (ctrl)
    );

    seq_loop_counters u_loops (
        .CLK      (CLK),
        .RSTL     (RSTL),
        .purge    (purge),
        .fire     (fire),
        .inst     (inst),
        .cnt_last (cnt_last)
    );

    // --------------------
    // Address generators
    // --------------------
    seq_addr_gen #(.HAS_BACKUP(1'b1)) u_raddr_x (
        .CLK   (CLK),
        .RSTL  (RSTL),
        .purge (purge),
        .fire  (fire),
        .field (inst.addr_rx),
        .addr  (raddr_x)
    );

    seq_addr_gen #(.HAS_BACKUP(1'b1)) u_raddr_w (
        .CLK   (CLK),
        .RSTL  (RSTL),
        .purge (purge),
        .fire  (fire),
        .field (inst.addr_rw),
        .addr  (raddr_w)
    );

    // Write side has no backup
    seq_addr_gen #(.HAS_BACKUP(1'b0)) u_waddr_x (
        .CLK   (CLK),
        .RSTL  (RSTL),
        .purge (purge),
        .fire  (fire),
        .field (inst.addr_wx),
        .addr  (waddr_x)
    );

    // Control pins
    assign bank_x  = ctrl.bank_x;
    assign bank_w  = ctrl.bank_w;
    assign rceb_x  = ctrl.rceb_x;
    assign wceb_x  = ctrl.wceb_x;
    assign req_w   = ctrl.req_w;
    assign mac_en  = ctrl.mac_en;
    assign nl_en   = ctrl.nl_en;
    assign nl_sel  = ctrl.nl_sel;
    assign seq_fin = ctrl.seq_fin;
    assign olsb    = ctrl.olsb;

endmodule

`default_nettype wire

/* src/seq_addr_gen.sv */
//--------------------
// Data-memory address generator
// Load, restore from backup, or step up/down on each fired word.
// The output latch shows the address one cycle later and holds in purge.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module seq_addr_gen #(
    parameter bit HAS_BACKUP = 1'b0
) (
    input  wire                            CLK,
    input  wire                            RSTL,
    input  wire                            purge,
    input  wire                            fire,
    input  wire seq_pkg::addr_field_t      field,
    output logic [seq_pkg::ADDR_W-1:0]     addr
);

    logic [seq_pkg::ADDR_W-1:0] addr_q;
    logic [seq_pkg::ADDR_W-1:0] bak_q;
    logic [seq_pkg::ADDR_W-1:0] step;
    logic                       sub;
    logic                       restore;

    // Sign-magnitude step
    assign sub     = field.value[seq_pkg::ADDR_W-1];
    assign step    = {1'b0, field.value[seq_pkg::ADDR_W-2:0]};
    assign restore = field.bak && (bak_q != '0);

    // --------------------
    // Address register
    // --------------------
    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
        begin
            addr_q <= '0;
        end
        else if (purge)
        begin
            addr_q <= '0;
        end
        else if (fire)
        begin
            if (field.we)
                addr_q <= field.value;
            else if (restore)
                addr_q <= bak_q;
            else if (sub)
                addr_q <= addr_q - step;
            else
                addr_q <= addr_q + step;
        end
    end

    // --------------------
    // Backup register
    // --------------------
    if (HAS_BACKUP)
    begin : g_bak
        // First bak saves, second bak clears
        always_ff @(posedge CLK or negedge RSTL)
        begin
            if (!RSTL)
                bak_q <= '0;
            else if (purge)
                bak_q <= '0;
            else if (fire && field.bak)
                bak_q <= (bak_q == '0) ? addr_q : '0;
        end
    end
    else
    begin : g_no_bak
        assign bak_q = '0;
    end

    // Output latch
    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
            addr <= '0;
        else if (!purge)
            addr <= addr_q;
    end

endmodule

`default_nettype wire

/* src/seq_loop_counters.sv */
//--------------------
// Loop counters of the sequencer
// Load when zero on cnt_we, count down when selected by a jump.
// cnt_last tells the issue stage which counters hold 1.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module seq_loop_counters (
    input  wire                              CLK,
    input  wire                              RSTL,
    input  wire                              purge,
    input  wire                              fire,
    input  wire seq_pkg::inst_t              inst,
    output logic [seq_pkg::NUM_LOOPS-1:0]    cnt_last
);

    localparam logic [seq_pkg::CNT_W-1:0] CNT_ONE = 1;

    for (genvar i = 0; i < seq_pkg::NUM_LOOPS; i++)
    begin : g_cnt
        localparam logic [seq_pkg::CNT_SEL_W-1:0] SEL = i;

        logic [seq_pkg::CNT_W-1:0] cnt_q;
        logic                      load_sel;

        assign load_sel    = inst.cnt_we && (inst.cnt_sel == SEL);
        assign cnt_last[i] = (cnt_q == CNT_ONE);

        always_ff @(posedge CLK or negedge RSTL)
        begin
            if (!RSTL)
            begin
                cnt_q <= '0;
            end
            else if (purge)
            begin
                cnt_q <= '0;
            end
            else if (fire)
            begin
                if (load_sel)
                begin
                    // A running loop keeps its count
                    if (cnt_q == '0)
                    begin
                        cnt_q <= inst.cnt_value;
                    end
                end
                else if (inst.jump_sel[i])
                begin
                    cnt_q <= cnt_q - CNT_ONE;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/seq_issue.sv */
//--------------------
// Issue stage of the sequencer
// Holds the PC and squash flag, decides stall, jump or next word,
// and registers the control field of each fired word.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module seq_issue (
    input  wire                               CLK,
    input  wire                               RSTL,
    input  wire                               purge,
    input  wire [seq_pkg::NUM_BUSY-1:0]       busy,
    input  wire [seq_pkg::INST_W-1:0]         instr,
    input  wire [seq_pkg::NUM_LOOPS-1:0]      cnt_last,
    output seq_pkg::inst_t                    inst,
    output logic                              fire,
    output logic [seq_pkg::PC_W-1:0]          inst_addr,
    output seq_pkg::ctrl_t                    ctrl
);

    localparam logic [seq_pkg::PC_W-1:0] PC_ONE = 1;

    logic [seq_pkg::PC_W-1:0] pc_q;
    // Address of the word now on instr
    logic [seq_pkg::PC_W-1:0] cur_addr_q;
    logic                     squash_q;
    logic                     stall;
    logic                     jump;

    assign inst      = instr;
    assign inst_addr = pc_q;

    // --------------------
    // Execute decision
    // --------------------

    // A squashed word never waits
    assign stall = !squash_q && (|(inst.wait_sel & busy));
    assign fire  = !squash_q && !stall;

    // Jump taken unless the selected counter is on its last pass
    assign jump  = fire && (|(inst.jump_sel & ~cnt_last));

    // --------------------
    // Program counter
    // --------------------
    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
        begin
            pc_q       <= '0;
            cur_addr_q <= '0;
            squash_q   <= 1'b1;
        end
        else
        begin
            cur_addr_q <= pc_q;
            if (purge)
            begin
                pc_q     <= '0;
                squash_q <= 1'b1;
            end
            else if (stall)
            begin
                // Present the waiting word again
                pc_q     <= cur_addr_q;
                squash_q <= 1'b1;
            end
            else if (jump)
            begin
                pc_q     <= inst.jump_target;
                squash_q <= 1'b1;
            end
            else
            begin
                pc_q     <= pc_q + PC_ONE;
                squash_q <= 1'b0;
            end
        end
    end

    // --------------------
    // Issued control pins
    // --------------------

    // One-cycle pulse per fired word, zero otherwise
    always_ff @(posedge CLK or negedge RSTL)
    begin
        if (!RSTL)
        begin
            ctrl <= '0;
        end
        else if (fire && !purge)
        begin
            ctrl <= inst.ctrl;
        end
        else
        begin
            ctrl <= '0;
        end
    end

endmodule

`default_nettype wire

/* src/seq_pkg.sv */
//--------------------
// Shared definitions of the microcode sequencer
// Widths, busy bit order and the 128-bit instruction word layout.
// Every sequencer file refers to these by scoped names.
//--------------------
`default_nettype none

package seq_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int PC_W      = 10;
    localparam int ADDR_W    = 16;
    localparam int CNT_W     = 16;
    localparam int NUM_LOOPS = 4;
    localparam int NUM_BUSY  = 3;
    localparam int INST_W    = 128;
    localparam int CNT_SEL_W = $clog2(NUM_LOOPS);

    // Bit positions in busy and wait_sel
    localparam int BUSY_W  = 0;
    localparam int BUSY_XI = 1;
    localparam int BUSY_XO = 2;

    // --------------------
    // Field types
    // --------------------

    // One address generator command.
    // With we clear, value[ADDR_W-1] picks subtract and the rest is the step.
    typedef struct packed {
        logic              we;
        logic              bak;
        logic [ADDR_W-1:0] value;
    } addr_field_t;

    // Control pins issued one cycle after the word fires
    typedef struct packed {
        logic       bank_x;
        logic       bank_w;
        logic       rceb_x;
        logic       wceb_x;
        logic       req_w;
        logic       mac_en;
        logic       nl_en;
        logic [1:0] nl_sel;
        logic       seq_fin;
        logic [3:0] olsb;
    } ctrl_t;

    localparam int USED_W = NUM_LOOPS + PC_W + NUM_BUSY + 1 + CNT_SEL_W + CNT_W
                          + 3 * $bits(addr_field_t) + $bits(ctrl_t);
    localparam int SPARE_W = INST_W - USED_W;

    // --------------------
    // Instruction word
    // --------------------
    typedef struct packed {
        logic [NUM_LOOPS-1:0] jump_sel;
        logic [PC_W-1:0]      jump_target;
        logic [NUM_BUSY-1:0]  wait_sel;
        logic                 cnt_we;
        logic [CNT_SEL_W-1:0] cnt_sel;
        logic [CNT_W-1:0]     cnt_value;
        addr_field_t          addr_rx;
        addr_field_t          addr_rw;
        addr_field_t          addr_wx;
        ctrl_t                ctrl;
        // Reserved, ignored by the sequencer
        logic [SPARE_W-1:0]   spare;
    } inst_t;

endpackage

`default_nettype wire
